// ==== filelist.f ====
common/pwm_pkg.sv
common/bus_pkg.sv
verilog/reg_decode.sv
pwm_channel/pwm_channel.sv
pwm_channel/tick_generator.sv
verilog/readback_mux.sv
verilog/pwm_timer_top.sv
dv/pwm_timer_chk.sv
dv/pwm_timer_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the testbench with Verilator and runs it from the project root.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module pwm_timer_tb -f filelist.f -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

output=$(./obj_dir/Vpwm_timer_tb)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

# The run counts as good only if the pass line was printed.
if echo "$output" | grep -qx "Testbench passed"; then
    exit 0
fi
exit 1

// ==== dv/pwm_timer_tb.sv ====
module pwm_timer_tb;
    import pwm_pkg::*;
    import bus_pkg::*;

    // long enough for four full periods per channel at divisor 3, plus slack.
    localparam int TIMEOUT_CYCLES = 4 * NUM_CHANNELS * (COUNT_START + 1) * 4 + 2000;
    localparam logic [ADDR_WIDTH-1:0] ADDR_CONTROL = {1'b1, REG_CONTROL};
    localparam logic [ADDR_WIDTH-1:0] ADDR_DIVISOR = {1'b1, REG_DIVISOR};

    logic                    sysclk;
    logic                    sysreset;
    logic                    wr_strobe;
    logic                    rd_strobe;
    logic [ADDR_WIDTH-1:0]   addr;
    logic [DATA_WIDTH-1:0]   wdata;
    logic                    ext_event;
    logic [DATA_WIDTH-1:0]   rdata;
    logic                    rd_valid;
    logic [NUM_CHANNELS-1:0] pwm_out;

    // outstanding reads and finished measurements wait here for the compare process.
    logic [DATA_WIDTH-1:0]  exp_read_q[$];
    logic                   exp_used_q[$];
    string                  exp_name_q[$];
    logic [COUNT_WIDTH-1:0] got_high_q[$];
    logic [COUNT_WIDTH-1:0] exp_high_q[$];
    string                  high_name_q[$];

    logic [DATA_WIDTH-1:0]  last_rdata;
    logic [COUNT_WIDTH-1:0] duty_val[NUM_CHANNELS];
    int errors;
    int checks;
    int tests;
    int errors_at_start;
    int cycle_count;

    pwm_timer_top dut0 (
        .sysclk    (sysclk),
        .sysreset  (sysreset),
        .wr_strobe (wr_strobe),
        .rd_strobe (rd_strobe),
        .addr      (addr),
        .wdata     (wdata),
        .ext_event (ext_event),
        .rdata     (rdata),
        .rd_valid  (rd_valid),
        .pwm_out   (pwm_out)
    );

    initial sysclk = 1'b0;
    always #10 sysclk = ~sysclk;

    // high cycles per PWM period: duty capped at the period, times the prescale.
    function automatic logic [COUNT_WIDTH-1:0] expected_high(input logic [COUNT_WIDTH-1:0] duty,
                                                             input int div);
        int capped;
        capped = (int'(duty) < COUNT_START + 1) ? int'(duty) : COUNT_START + 1;
        return COUNT_WIDTH'(capped * (div + 1));
    endfunction

    // channel address is the top bit clear, then the channel index and selector.
    function automatic logic [ADDR_WIDTH-1:0] chan_addr(input int c, input logic sel);
        logic [1:0] idx;
        idx = 2'(c);
        return {1'b0, idx, sel};
    endfunction

    task automatic check_read(input logic [DATA_WIDTH-1:0] got, input logic [DATA_WIDTH-1:0] exp,
                              input string name);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("mismatch at %0t: %s read 0x%04h, expected 0x%04h", $time, name, got, exp);
        end
    endtask

    task automatic check_high(input logic [COUNT_WIDTH-1:0] got,
                              input logic [COUNT_WIDTH-1:0] exp, input string name);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("mismatch at %0t: %s high for %0d cycles, expected %0d", $time, name, got, exp);
        end
    endtask

    // outputs are sampled on the falling edge, half a cycle after they settle.
    always @(negedge sysclk) begin
        if (rd_valid) begin
            if (exp_read_q.size() == 0) begin
                errors++;
                $display("rd_valid rose at %0t with no read outstanding", $time);
            end else begin
                last_rdata = rdata;
                if (exp_used_q[0]) begin
                    check_read(rdata, exp_read_q[0], exp_name_q[0]);
                end
                void'(exp_read_q.pop_front());
                void'(exp_used_q.pop_front());
                void'(exp_name_q.pop_front());
            end
        end
        while (got_high_q.size() > 0) begin
            check_high(got_high_q[0], exp_high_q[0], high_name_q[0]);
            void'(got_high_q.pop_front());
            void'(exp_high_q.pop_front());
            void'(high_name_q.pop_front());
        end
    end

    always @(posedge sysclk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Testbench failed");
            $finish;
        end
    end

    // every bus task starts and ends 2 time units after a rising edge.
    task automatic wait_cycles(input int n);
        repeat (n) @(posedge sysclk);
        #2;
    endtask

    task automatic write_reg(input logic [ADDR_WIDTH-1:0] a, input logic [DATA_WIDTH-1:0] d);
        addr      = a;
        wdata     = d;
        wr_strobe = 1'b1;
        wait_cycles(1);
        wr_strobe = 1'b0;
    endtask

    task automatic read_reg(input logic [ADDR_WIDTH-1:0] a, input logic [DATA_WIDTH-1:0] exp,
                            input logic use_exp, input string name);
        exp_read_q.push_back(exp);
        exp_used_q.push_back(use_exp);
        exp_name_q.push_back(name);
        addr      = a;
        rd_strobe = 1'b1;
        wait_cycles(1);
        rd_strobe = 1'b0;
        @(negedge sysclk);
        if (!rd_valid) begin
            errors++;
            $display("read of %s at %0t got no rd_valid the cycle after its strobe", name, $time);
            void'(exp_read_q.pop_front());
            void'(exp_used_q.pop_front());
            void'(exp_name_q.pop_front());
        end
        wait_cycles(1);
    endtask

    // counts high cycles on every channel over one full PWM period.
    task automatic measure_high(input int div, input string name);
        int high_cnt[NUM_CHANNELS];
        int period;
        period = (COUNT_START + 1) * (div + 1);
        for (int c = 0; c < NUM_CHANNELS; c++) begin
            high_cnt[c] = 0;
        end
        repeat (period) begin
            @(negedge sysclk);
            for (int c = 0; c < NUM_CHANNELS; c++) begin
                if (pwm_out[c]) begin
                    high_cnt[c]++;
                end
            end
        end
        for (int c = 0; c < NUM_CHANNELS; c++) begin
            got_high_q.push_back(COUNT_WIDTH'(high_cnt[c]));
            exp_high_q.push_back(expected_high(duty_val[c], div));
            high_name_q.push_back($sformatf("%s ch%0d", name, c));
        end
        wait_cycles(1);
    endtask

    task automatic pulse_event(input int high_cycles, input int low_cycles);
        ext_event = 1'b1;
        wait_cycles(high_cycles);
        ext_event = 1'b0;
        wait_cycles(low_cycles);
    endtask

    task automatic report_test(input string name);
        int new_errors;
        wait_cycles(2);
        new_errors = errors - errors_at_start;
        tests++;
        if (new_errors == 0) begin
            $display("test %0d %s: ok", tests, name);
        end else begin
            $display("test %0d %s: %0d errors", tests, name, new_errors);
        end
        errors_at_start = errors;
    endtask

    initial begin
        logic [DATA_WIDTH-1:0] div_word;
        logic [DATA_WIDTH-1:0] count_before;
        logic [DATA_WIDTH-1:0] count_expect;
        int n_pulses;
        int div_list[2];
        void'($urandom(74));
        sysreset        = 1'b1;
        wr_strobe       = 1'b0;
        rd_strobe       = 1'b0;
        addr            = '0;
        wdata           = '0;
        ext_event       = 1'b0;
        last_rdata      = '0;
        errors          = 0;
        checks          = 0;
        tests           = 0;
        errors_at_start = 0;
        cycle_count     = 0;
        div_list[0]     = 0;
        div_list[1]     = 3;
        repeat (10) @(posedge sysclk);
        #2;
        sysreset = 1'b0;
        wait_cycles(2);

        // register write and read-back, with the timer still disabled.
        for (int c = 0; c < NUM_CHANNELS; c++) begin
            duty_val[c] = COUNT_WIDTH'($urandom_range(COUNT_START + 1, 1));
            write_reg(chan_addr(c, SEL_DUTY), DATA_WIDTH'(duty_val[c]));
        end
        div_word = DATA_WIDTH'($urandom);
        write_reg(ADDR_DIVISOR, div_word);
        for (int c = 0; c < NUM_CHANNELS; c++) begin
            read_reg(chan_addr(c, SEL_DUTY), DATA_WIDTH'(duty_val[c]), 1'b1,
                     $sformatf("duty ch%0d", c));
        end
        // only the low divisor bits are stored.
        read_reg(ADDR_DIVISOR, DATA_WIDTH'(div_word[DIV_WIDTH-1:0]), 1'b1, "divisor");
        write_reg(ADDR_CONTROL, 16'h0002);
        read_reg(ADDR_CONTROL, 16'h0002, 1'b1, "control");
        write_reg(ADDR_CONTROL, 16'h0001);
        read_reg(ADDR_CONTROL, 16'h0001, 1'b1, "control");
        write_reg(ADDR_CONTROL, 16'h0000);
        read_reg(ADDR_CONTROL, 16'h0000, 1'b1, "control");
        read_reg(4'hA, 16'h0000, 1'b1, "unmapped 0xa");
        read_reg(4'hF, 16'h0000, 1'b1, "unmapped 0xf");
        report_test("register read-back");

        // prescaled PWM at two divisors; the settle covers a full period.
        write_reg(ADDR_CONTROL, 16'h0001);
        for (int i = 0; i < 2; i++) begin
            write_reg(ADDR_DIVISOR, DATA_WIDTH'(div_list[i]));
            wait_cycles((COUNT_START + 1) * (div_list[i] + 1) + 8);
            measure_high(div_list[i], $sformatf("div %0d", div_list[i]));
        end
        report_test("prescaled high time");

        // duty at both bounds gives a constant low or constant high output.
        duty_val[0] = '0;
        duty_val[1] = COUNT_WIDTH'(COUNT_START + 1);
        duty_val[2] = COUNT_WIDTH'(COUNT_START + 1);
        duty_val[3] = '0;
        for (int c = 0; c < NUM_CHANNELS; c++) begin
            write_reg(chan_addr(c, SEL_DUTY), DATA_WIDTH'(duty_val[c]));
        end
        wait_cycles(8);
        measure_high(3, "bound");
        report_test("duty bounds");

        // a disabled timer holds its counters.
        write_reg(ADDR_CONTROL, 16'h0000);
        wait_cycles(3);
        read_reg(chan_addr(0, SEL_COUNT), '0, 1'b0, "count ch0");
        count_before = last_rdata;
        wait_cycles(200);
        read_reg(chan_addr(0, SEL_COUNT), count_before, 1'b1, "count ch0 held");
        report_test("disabled hold");

        // each external rising edge moves the counter down by one, with wrap.
        write_reg(ADDR_CONTROL, 16'h0003);
        wait_cycles(10);
        read_reg(chan_addr(2, SEL_COUNT), '0, 1'b0, "count ch2");
        count_before = last_rdata;
        n_pulses = int'($urandom_range(20, 5));
        for (int i = 0; i < n_pulses; i++) begin
            pulse_event(2 + int'($urandom_range(2)), 2 + int'($urandom_range(2)));
        end
        wait_cycles(10);
        count_expect = DATA_WIDTH'((int'(count_before) + (COUNT_START + 1)
                                    - (n_pulses % (COUNT_START + 1))) % (COUNT_START + 1));
        read_reg(chan_addr(2, SEL_COUNT), count_expect, 1'b1, "count ch2 after events");
        report_test("external events");

        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

// ==== dv/pwm_timer_chk.sv ====
module pwm_timer_chk (
    input logic                            sysclk,
    input logic                            sysreset,
    input logic                            tick,
    input logic [pwm_pkg::COUNT_WIDTH-1:0] counter_value,
    input logic [pwm_pkg::COUNT_WIDTH-1:0] duty,
    input logic                            pwm_out
);
    import pwm_pkg::*;

    // the reload value is the highest count a channel can ever hold.
    counter_in_range: assert property (
        @(posedge sysclk) disable iff (sysreset)
        counter_value <= COUNT_WIDTH'(COUNT_START)
    ) else $error("counter value %0d is above the reload value", counter_value);

    // with a duty of 0 the compare is never true, so the registered output
    // must be low one cycle later.
    zero_duty_low: assert property (
        @(posedge sysclk) disable iff (sysreset)
        (duty == '0) |=> !pwm_out
    ) else $error("pwm_out is high after a cycle with duty 0");

    // a tick on a non-zero counter moves it down by exactly one.
    tick_decrements: assert property (
        @(posedge sysclk) disable iff (sysreset)
        (tick && counter_value != '0) |=> (counter_value == $past(counter_value) - 1'b1)
    ) else $error("counter did not decrement by one on a tick");

endmodule

bind pwm_channel pwm_timer_chk chk0 (
    .sysclk        (sysclk),
    .sysreset      (sysreset),
    .tick          (tick),
    .counter_value (counter_value),
    .duty          (duty),
    .pwm_out       (pwm_out)
);

// ==== verilog/pwm_timer_top.sv ====
module pwm_timer_top (
    input  logic                               sysclk,
    input  logic                               sysreset,
    input  logic                               wr_strobe,
    input  logic                               rd_strobe,
    input  logic [bus_pkg::ADDR_WIDTH-1:0]     addr,
    input  logic [bus_pkg::DATA_WIDTH-1:0]     wdata,
    input  logic                               ext_event,
    output logic [bus_pkg::DATA_WIDTH-1:0]     rdata,
    output logic                               rd_valid,
    output logic [pwm_pkg::NUM_CHANNELS-1:0]   pwm_out
);
    import pwm_pkg::*;

    // decode to channel and tick generator.
    logic [NUM_CHANNELS-1:0] duty_load;
    logic [COUNT_WIDTH-1:0]  load_data;
    logic                    enable;
    logic                    tick_src;
    logic [DIV_WIDTH-1:0]    divisor;
    logic                    tick;

    // channel state gathered for the read path.
    logic [NUM_CHANNELS-1:0][COUNT_WIDTH-1:0] counter_values;
    logic [NUM_CHANNELS-1:0][COUNT_WIDTH-1:0] duties;

    reg_decode decode0 (
        .sysclk    (sysclk),
        .sysreset  (sysreset),
        .wr_strobe (wr_strobe),
        .addr      (addr),
        .wdata     (wdata),
        .duty_load (duty_load),
        .load_data (load_data),
        .enable    (enable),
        .tick_src  (tick_src),
        .divisor   (divisor)
    );

    tick_generator tickgen0 (
        .sysclk    (sysclk),
        .sysreset  (sysreset),
        .enable    (enable),
        .tick_src  (tick_src),
        .divisor   (divisor),
        .ext_event (ext_event),
        .tick      (tick)
    );

    // all channels share the tick and the load data bus.
    for (genvar i = 0; i < NUM_CHANNELS; i++) begin : g_chan
        pwm_channel chan (
            .sysclk        (sysclk),
            .sysreset      (sysreset),
            .tick          (tick),
            .duty_load     (duty_load[i]),
            .load_data     (load_data),
            .counter_value (counter_values[i]),
            .duty          (duties[i]),
            .pwm_out       (pwm_out[i])
        );
    end

    readback_mux readback0 (
        .sysclk         (sysclk),
        .sysreset       (sysreset),
        .rd_strobe      (rd_strobe),
        .addr           (addr),
        .enable         (enable),
        .tick_src       (tick_src),
        .divisor        (divisor),
        .counter_values (counter_values),
        .duties         (duties),
        .rdata          (rdata),
        .rd_valid       (rd_valid)
    );

endmodule

// ==== verilog/readback_mux.sv ====
module readback_mux (
    input  logic                                                     sysclk,
    input  logic                                                     sysreset,
    input  logic                                                     rd_strobe,
    input  bus_pkg::addr_word_t                                      addr,
    input  logic                                                     enable,
    input  logic                                                     tick_src,
    input  logic [pwm_pkg::DIV_WIDTH-1:0]                            divisor,
    input  logic [pwm_pkg::NUM_CHANNELS-1:0][pwm_pkg::COUNT_WIDTH-1:0] counter_values,
    input  logic [pwm_pkg::NUM_CHANNELS-1:0][pwm_pkg::COUNT_WIDTH-1:0] duties,
    output logic [bus_pkg::DATA_WIDTH-1:0]                           rdata,
    output logic                                                     rd_valid
);
    import bus_pkg::*;

    logic [DATA_WIDTH-1:0] sel_data;

    // pick the addressed register in the strobe cycle.
    // anything that is not mapped reads as zero.
    always_comb begin
        sel_data = '0;
        if (addr.glob.global_sel) begin
            if (addr.glob.reg_num == REG_CONTROL) begin
                sel_data[CTRL_ENABLE]   = enable;
                sel_data[CTRL_TICK_SRC] = tick_src;
            end else if (addr.glob.reg_num == REG_DIVISOR) begin
                sel_data = DATA_WIDTH'(divisor);
            end
        end else begin
            if (addr.chan.reg_sel == SEL_DUTY) begin
                sel_data = DATA_WIDTH'(duties[addr.chan.channel]);
            end else if (addr.chan.reg_sel == SEL_COUNT) begin
                sel_data = DATA_WIDTH'(counter_values[addr.chan.channel]);
            end
        end
    end

    // read data is only meaningful while rd_valid is high.
    always_ff @(posedge sysclk) begin
        if (rd_strobe) begin
            rdata <= sel_data;
        end
    end

    // the valid strobe follows the read strobe by exactly one cycle.
    always_ff @(posedge sysclk or posedge sysreset) begin
        if (sysreset) begin
            rd_valid <= 1'b0;
        end else begin
            rd_valid <= rd_strobe;
        end
    end

endmodule

// ==== pwm_channel/tick_generator.sv ====
module tick_generator (
    input  logic                          sysclk,
    input  logic                          sysreset,
    input  logic                          enable,
    input  logic                          tick_src,
    input  logic [pwm_pkg::DIV_WIDTH-1:0] divisor,
    input  logic                          ext_event,
    output logic                          tick
);
    import pwm_pkg::*;

    logic [DIV_WIDTH-1:0]   pre_cnt;
    logic                   pre_done;
    logic [SYNC_STAGES-1:0] sync_q;
    logic                   event_last;
    logic                   ext_tick;

    // prescaler.
    // the count runs from 0 up to the divisor, giving one tick every
    // divisor+1 cycles.
    // the compare is >= so a divisor lowered below the running count
    // wraps at once instead of running through the whole count range.
    assign pre_done = (pre_cnt >= divisor);

    always_ff @(posedge sysclk or posedge sysreset) begin
        if (sysreset) begin
            pre_cnt <= '0;
        end else if (!enable || tick_src) begin
            // parked at zero whenever the prescaler is not the active source.
            pre_cnt <= '0;
        end else if (pre_done) begin
            pre_cnt <= '0;
        end else begin
            pre_cnt <= pre_cnt + 1'b1;
        end
    end

    // the event pin is asynchronous, so it passes through a short
    // synchronizer before the edge detector looks at it.
    always_ff @(posedge sysclk or posedge sysreset) begin
        if (sysreset) begin
            sync_q     <= '0;
            event_last <= 1'b0;
        end else begin
            sync_q     <= {sync_q[SYNC_STAGES-2:0], ext_event};
            event_last <= sync_q[SYNC_STAGES-1];
        end
    end

    // rising edge of the synchronized pin, registered once more.
    // an edge on the pin becomes a tick SYNC_STAGES+1 cycles later.
    always_ff @(posedge sysclk or posedge sysreset) begin
        if (sysreset) begin
            ext_tick <= 1'b0;
        end else begin
            ext_tick <= sync_q[SYNC_STAGES-1] && !event_last;
        end
    end

    // one shared tick for all channels, suppressed while disabled.
    assign tick = enable && (tick_src ? ext_tick : pre_done);

endmodule

// ==== pwm_channel/pwm_channel.sv ====
module pwm_channel (
    input  logic                            sysclk,
    input  logic                            sysreset,
    input  logic                            tick,
    input  logic                            duty_load,
    input  logic [pwm_pkg::COUNT_WIDTH-1:0] load_data,
    output logic [pwm_pkg::COUNT_WIDTH-1:0] counter_value,
    output logic [pwm_pkg::COUNT_WIDTH-1:0] duty,
    output logic                            pwm_out
);
    import pwm_pkg::*;

    // one countdown PWM channel.
    // the period is fixed at build time by COUNT_START, while the duty value
    // is written by software.
    // the counter is visible on the bus so software can line up with it,
    // which also makes the channel usable as a plain periodic timer.
    // a duty of 0 keeps the output low and COUNT_START+1 keeps it high.
    // duty is not double buffered, so a change mid-period can produce one
    // short or long pulse.
    // the safest moment to change it is just after the counter reloads.

    localparam logic [COUNT_WIDTH-1:0] RELOAD = COUNT_WIDTH'(COUNT_START);

    logic [COUNT_WIDTH-1:0] cnt;
    logic                   expired;
    logic                   pwm_comb;

    assign expired       = (cnt == '0);
    assign counter_value = cnt;

    // the counter only moves on the shared tick.
    // it reloads on the tick that finds it at zero, so each value is held
    // for one full tick interval.
    always_ff @(posedge sysclk or posedge sysreset) begin
        if (sysreset) begin
            cnt <= '0;
        end else if (tick) begin
            if (expired) begin
                cnt <= RELOAD;
            end else begin
                cnt <= cnt - 1'b1;
            end
        end
    end

    // duty register, written from the bus decode.
    always_ff @(posedge sysclk or posedge sysreset) begin
        if (sysreset) begin
            duty <= '0;
        end else if (duty_load) begin
            duty <= load_data;
        end
    end

    // the compare result is registered before it leaves the chip.
    // this keeps decode glitches off the pin at the cost of one cycle of lag.
    assign pwm_comb = (cnt < duty);

    always_ff @(posedge sysclk or posedge sysreset) begin
        if (sysreset) begin
            pwm_out <= 1'b0;
        end else begin
            pwm_out <= pwm_comb;
        end
    end

endmodule

// ==== verilog/reg_decode.sv ====
module reg_decode (
    input  logic                                sysclk,
    input  logic                                sysreset,
    input  logic                                wr_strobe,
    input  bus_pkg::addr_word_t                 addr,
    input  logic [bus_pkg::DATA_WIDTH-1:0]      wdata,
    output logic [pwm_pkg::NUM_CHANNELS-1:0]    duty_load,
    output logic [pwm_pkg::COUNT_WIDTH-1:0]     load_data,
    output logic                                enable,
    output logic                                tick_src,
    output logic [pwm_pkg::DIV_WIDTH-1:0]       divisor
);
    import bus_pkg::*;
    import pwm_pkg::*;

    // the top address bit tells the two views apart.
    logic is_global;
    logic ctrl_write;
    logic div_write;

    assign is_global  = addr.glob.global_sel;
    assign ctrl_write = wr_strobe && is_global && (addr.glob.reg_num == REG_CONTROL);
    assign div_write  = wr_strobe && is_global && (addr.glob.reg_num == REG_DIVISOR);

    // duty writes go straight to the channel, which registers them itself.
    // this way a duty write lands in the channel on the same edge as the strobe.
    // writes to a counter selector fall through and are dropped.
    always_comb begin
        duty_load = '0;
        if (wr_strobe && !addr.chan.global_sel && (addr.chan.reg_sel == SEL_DUTY)) begin
            duty_load[addr.chan.channel] = 1'b1;
        end
    end

    // the duty registers are as wide as the data bus.
    assign load_data = COUNT_WIDTH'(wdata);

    // control register.
    // only the enable and tick source bits are stored; the rest read back as 0.
    always_ff @(posedge sysclk or posedge sysreset) begin
        if (sysreset) begin
            enable   <= 1'b0;
            tick_src <= 1'b0;
        end else if (ctrl_write) begin
            enable   <= wdata[CTRL_ENABLE];
            tick_src <= wdata[CTRL_TICK_SRC];
        end
    end

    // prescaler divisor register.
    // the upper data bits are ignored on a write.
    always_ff @(posedge sysclk or posedge sysreset) begin
        if (sysreset) begin
            divisor <= '0;
        end else if (div_write) begin
            divisor <= wdata[DIV_WIDTH-1:0];
        end
    end

endmodule

// ==== common/bus_pkg.sv ====
package bus_pkg;

    // register bus widths.
    localparam int ADDR_WIDTH = 4;
    localparam int DATA_WIDTH = 16;

    // global register numbers, used when the address top bit is set.
    localparam logic [ADDR_WIDTH-2:0] REG_CONTROL = 3'd0;
    localparam logic [ADDR_WIDTH-2:0] REG_DIVISOR = 3'd1;

    // bit positions inside the control register.
    // the tick source bit picks the prescaler when 0 and the event pin when 1.
    localparam int CTRL_ENABLE   = 0;
    localparam int CTRL_TICK_SRC = 1;

    // per-channel register selectors, used when the address top bit is clear.
    localparam logic SEL_DUTY  = 1'b0;
    localparam logic SEL_COUNT = 1'b1;

    // channel view of the address.
    // the top bit is 0, then the channel index, then the register selector.
    typedef struct packed {
        logic       global_sel;
        logic [1:0] channel;
        logic       reg_sel;
    } chan_view_t;

    // global view of the address, with the top bit set to 1.
    typedef struct packed {
        logic                  global_sel;
        logic [ADDR_WIDTH-2:0] reg_num;
    } glob_view_t;

    // one bus address word, decoded either way depending on its top bit.
    typedef union packed {
        chan_view_t chan;
        glob_view_t glob;
    } addr_word_t;

endpackage

// ==== common/pwm_pkg.sv ====
package pwm_pkg;

    // every channel counter and duty register shares this width.
    localparam int COUNT_WIDTH = 16;

    // the countdown reload value is fixed when the design is built.
    // a reload of 99 gives a period of 100 ticks.
    localparam int COUNT_START = 99;

    // number of independent PWM outputs.
    localparam int NUM_CHANNELS = 4;

    // the prescaler divides the clock by divisor+1, so an 8-bit divisor
    // spans a division of 1 up to 256.
    localparam int DIV_WIDTH = 8;

    // flops used to bring the asynchronous event pin into the clock domain.
    localparam int SYNC_STAGES = 2;

endpackage
